//--- arrow_geometry.sv
`timescale 1ns/10ps

module arrow_geometry (
    input  logic             clk_in,
    input  geom_pkg::coord_t rel_x,
    input  geom_pkg::coord_t rel_y,
    input  geom_pkg::coord_t rel_z,
    input  geom_pkg::coord_t blk_x,
    input  geom_pkg::coord_t blk_y,
    input  geom_pkg::coord_t blk_z,
    output logic             in_region_a,
    output logic             in_region_c,
    output logic             in_bounds,
    output logic             ray_left,
    output logic             ray_below,
    output logic             on_top_face
);

    import geom_pkg::*;

    // two guard bits keep sums and chained differences exact
    typedef logic signed [$bits(coord_t)+1:0] wide_t;

    function automatic wide_t widen(coord_t v);
        return wide_t'(v);
    endfunction

    ////////////////////////////////////////
    // diagonal split of the top face

    // the two diagonals through the block centre cut the face
    // into four triangles, one per arrow direction
    wide_t ray_sum;
    wide_t blk_sum;
    wide_t ray_diff;
    wide_t blk_diff;

    assign ray_sum  = widen(rel_x) + widen(rel_y);
    assign blk_sum  = widen(blk_x) + widen(blk_y);
    assign ray_diff = widen(rel_y) - widen(rel_x);
    assign blk_diff = widen(blk_y) - widen(blk_x);

    ////////////////////////////////////////
    // arrow square and face height

    logic  x_inside;
    logic  y_inside;
    wide_t face_dz;

    // strict bounds on both sides
    assign x_inside = (widen(rel_x) > widen(blk_x) - widen(ARROW_HALF_WIDTH))
                   && (widen(rel_x) < widen(blk_x) + widen(ARROW_HALF_WIDTH));
    assign y_inside = (widen(rel_y) > widen(blk_y) - widen(ARROW_HALF_WIDTH))
                   && (widen(rel_y) < widen(blk_y) + widen(ARROW_HALF_WIDTH));

    // height of the hit above the top face
    assign face_dz = widen(rel_z) - widen(blk_z) - widen(TOP_FACE_HEIGHT);

    always_ff @(posedge clk_in) begin
        in_region_a <= (ray_sum < blk_sum);
        in_region_c <= (ray_diff < blk_diff);
        in_bounds   <= x_inside && y_inside;
        ray_left    <= (rel_x < blk_x);
        ray_below   <= (rel_y < blk_y);
        on_top_face <= (face_dz <= widen(TOP_FACE_SLACK));
    end

endmodule

//--- geom_pkg.sv
package geom_pkg;

    ////////////////////////////////////////
    // fixed-point format

    // fraction bits of every coordinate
    localparam int FRAC_BITS = 8;

    // coordinates, hit distance t and ray components
    typedef logic signed [31:0] coord_t;

    ////////////////////////////////////////
    // scene geometry

    // eye position in the ground plane
    // block positions are moved into the eye frame with it
    localparam coord_t EYE_X = coord_t'(1800 << FRAC_BITS);
    localparam coord_t EYE_Y = coord_t'(1800 << FRAC_BITS);

    // top face sits this far above the block position
    localparam coord_t TOP_FACE_HEIGHT = coord_t'(200 << FRAC_BITS);

    // tolerance on the top-face test, about 0.01
    localparam coord_t TOP_FACE_SLACK = coord_t'(3);

    // half-extent of the arrow square in x and y
    localparam coord_t ARROW_HALF_WIDTH = coord_t'(80 << FRAC_BITS);

    ////////////////////////////////////////
    // block arrow direction

    // codes 4 to 7 draw like LEFT
    typedef enum logic [2:0] {
        UP    = 3'd0,
        RIGHT = 3'd1,
        DOWN  = 3'd2,
        LEFT  = 3'd3,
        ANY   = 3'd4
    } arrow_dir_t;

endpackage

//--- pixel_color.sv
`timescale 1ns/10ps

module pixel_color (
    input  logic                    clk_in,
    input  logic                    rst_in,
    input  logic                    valid_in,
    input  geom_pkg::coord_t        block_pos_x,
    input  geom_pkg::coord_t        block_pos_y,
    input  geom_pkg::coord_t        block_pos_z,
    input  geom_pkg::coord_t        ray_x,
    input  geom_pkg::coord_t        ray_y,
    input  geom_pkg::coord_t        ray_z,
    input  geom_pkg::coord_t        t_in,
    input  geom_pkg::arrow_dir_t    block_dir,
    input  shade_pkg::block_color_t block_color,
    output shade_pkg::chan_t        r_out,
    output shade_pkg::chan_t        g_out,
    output shade_pkg::chan_t        b_out,
    output logic                    rgb_valid
);

    // stage 1, scaled ray and block in the eye frame
    geom_pkg::coord_t rel_x;
    geom_pkg::coord_t rel_y;
    geom_pkg::coord_t rel_z;
    geom_pkg::coord_t blk_x;
    geom_pkg::coord_t blk_y;
    geom_pkg::coord_t blk_z;

    // stage 2, geometry flags and aligned attributes
    logic                    in_region_a;
    logic                    in_region_c;
    logic                    in_bounds;
    logic                    ray_left;
    logic                    ray_below;
    logic                    on_top_face;
    geom_pkg::arrow_dir_t    s2_dir;
    shade_pkg::block_color_t s2_color;
    logic                    out_strobe;

    pixel_pipe_ctrl i_pipe_ctrl (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .valid_in    (valid_in),
        .block_dir   (block_dir),
        .block_color (block_color),
        .s2_dir      (s2_dir),
        .s2_color    (s2_color),
        .out_strobe  (out_strobe)
    );

    ray_scaler i_ray_scaler (
        .clk_in      (clk_in),
        .ray_x       (ray_x),
        .ray_y       (ray_y),
        .ray_z       (ray_z),
        .t_in        (t_in),
        .block_pos_x (block_pos_x),
        .block_pos_y (block_pos_y),
        .block_pos_z (block_pos_z),
        .rel_x       (rel_x),
        .rel_y       (rel_y),
        .rel_z       (rel_z),
        .blk_x       (blk_x),
        .blk_y       (blk_y),
        .blk_z       (blk_z)
    );

    arrow_geometry i_arrow_geometry (
        .clk_in      (clk_in),
        .rel_x       (rel_x),
        .rel_y       (rel_y),
        .rel_z       (rel_z),
        .blk_x       (blk_x),
        .blk_y       (blk_y),
        .blk_z       (blk_z),
        .in_region_a (in_region_a),
        .in_region_c (in_region_c),
        .in_bounds   (in_bounds),
        .ray_left    (ray_left),
        .ray_below   (ray_below),
        .on_top_face (on_top_face)
    );

    pixel_shader i_pixel_shader (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .in_region_a (in_region_a),
        .in_region_c (in_region_c),
        .in_bounds   (in_bounds),
        .ray_left    (ray_left),
        .ray_below   (ray_below),
        .on_top_face (on_top_face),
        .s2_dir      (s2_dir),
        .s2_color    (s2_color),
        .out_strobe  (out_strobe),
        .r_out       (r_out),
        .g_out       (g_out),
        .b_out       (b_out),
        .rgb_valid   (rgb_valid)
    );

endmodule

//--- pixel_color_properties.sv
`timescale 1ns/10ps

module pixel_color_properties (
    input logic             clk_in,
    input logic             rst_in,
    input logic             valid_in,
    input logic             rgb_valid,
    input shade_pkg::chan_t r_out,
    input shade_pkg::chan_t g_out,
    input shade_pkg::chan_t b_out
);

    import shade_pkg::*;

    ////////////////////////////////////////
    // handshake timing

    // one result per strobe, PIPE_STAGES edges later
    valid_latency: assert property (@(posedge clk_in) disable iff (rst_in)
        rgb_valid == $past(valid_in, PIPE_STAGES))
        else $error("rgb_valid is not valid_in delayed by %0d cycles", PIPE_STAGES);

    // cleared by every clock edge in reset
    valid_in_reset: assert property (@(posedge clk_in)
        $past(rst_in) |-> !rgb_valid)
        else $error("rgb_valid high while reset is applied");

    ////////////////////////////////////////
    // output values

    // unlit shading, so only off or full intensity
    channel_levels: assert property (@(posedge clk_in) disable iff (rst_in)
        rgb_valid |-> ((r_out == '0) || (r_out == CHAN_ONE))
                   && ((g_out == '0) || (g_out == CHAN_ONE))
                   && ((b_out == '0) || (b_out == CHAN_ONE)))
        else $error("colour channel neither zero nor full intensity");

endmodule

bind pixel_color pixel_color_properties i_pixel_color_properties (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .valid_in  (valid_in),
    .rgb_valid (rgb_valid),
    .r_out     (r_out),
    .g_out     (g_out),
    .b_out     (b_out)
);

//--- pixel_color_tb.sv
`timescale 1ns/10ps

module pixel_color_tb;

    import geom_pkg::*;
    import shade_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_DIRECTED = 45;
    localparam int NUM_RANDOM = 200;
    localparam int NUM_VECTORS = NUM_DIRECTED + NUM_RANDOM;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_VECTORS + PIPE_STAGES + 20;

    typedef struct packed {
        chan_t r;
        chan_t g;
        chan_t b;
        int    due;
    } expect_t;

    logic         clk_in;
    logic         rst_in;
    logic         valid_in;
    coord_t       block_pos_x;
    coord_t       block_pos_y;
    coord_t       block_pos_z;
    coord_t       ray_x;
    coord_t       ray_y;
    coord_t       ray_z;
    coord_t       t_in;
    arrow_dir_t   block_dir;
    block_color_t block_color;
    chan_t        r_out;
    chan_t        g_out;
    chan_t        b_out;
    logic         rgb_valid;

    expect_t exp_q[$];
    int      cyc = 0;
    int      check_count = 0;
    int      error_count = 0;

    // one hit point inside each quadrant of the arrow square: up, right, down, left
    int quad_dx[4] = '{0, 40, 0, -40};
    int quad_dy[4] = '{-40, 0, 40, 0};

    pixel_color i_pixel_color (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .valid_in    (valid_in),
        .block_pos_x (block_pos_x),
        .block_pos_y (block_pos_y),
        .block_pos_z (block_pos_z),
        .ray_x       (ray_x),
        .ray_y       (ray_y),
        .ray_z       (ray_z),
        .t_in        (t_in),
        .block_dir   (block_dir),
        .block_color (block_color),
        .r_out       (r_out),
        .g_out       (g_out),
        .b_out       (b_out),
        .rgb_valid   (rgb_valid)
    );

    initial begin
        clk_in = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk_in = ~clk_in;
        end
    end

    always @(posedge clk_in) begin
        cyc <= cyc + 1;
    end

    task automatic check_value(string name, longint actual, longint expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("** Error at %0t: %s = %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    ////////////////////////////////////////
    // reference model

    // offsets of the hit from the block centre decide every flag
    function automatic expect_t shade_model(coord_t pos_x, coord_t pos_y, coord_t pos_z,
            coord_t rx, coord_t ry, coord_t rz, coord_t t, logic [2:0] dir, logic [2:0] col);
        longint  dx;
        longint  dy;
        longint  dz;
        longint  half;
        logic    hit;
        chan_t   bright;
        expect_t e;
        dx = ((longint'(rx) * longint'(t)) >>> FRAC_BITS) - (longint'(pos_x) - longint'(EYE_X));
        dy = ((longint'(ry) * longint'(t)) >>> FRAC_BITS) - (longint'(pos_y) - longint'(EYE_Y));
        dz = ((longint'(rz) * longint'(t)) >>> FRAC_BITS) - longint'(pos_z)
           - longint'(TOP_FACE_HEIGHT);
        half = longint'(ARROW_HALF_WIDTH);
        case (dir)
            UP:      hit = (dy < 0) && (dx + dy < 0) && (dy - dx < 0);
            RIGHT:   hit = (dx >= 0) && (dx + dy >= 0) && (dy - dx < 0);
            DOWN:    hit = (dy >= 0) && (dx + dy >= 0) && (dy - dx >= 0);
            default: hit = (dx < 0) && (dx + dy < 0) && (dy - dx >= 0);
        endcase
        hit = hit && (dz <= longint'(TOP_FACE_SLACK));
        hit = hit && (dx > -half) && (dx < half) && (dy > -half) && (dy < half);
        e.r = (col == 3'd1) ? CHAN_ONE : chan_t'(0);
        e.g = chan_t'(0);
        e.b = (col == 3'd0) ? CHAN_ONE : chan_t'(0);
        e.due = 0;
        bright = (e.r > e.b) ? e.r : e.b;
        if (hit) begin
            e.r = bright;
            e.g = bright;
            e.b = bright;
        end
        return e;
    endfunction

    ////////////////////////////////////////
    // stimulus

    // dx, dy in whole units from the block centre, dz in LSB above the top face
    task automatic send_pixel(logic v, int dx, int dy, int dz, logic [2:0] dir, logic [2:0] col);
        coord_t  bx;
        coord_t  by;
        expect_t e;
        @(negedge clk_in);
        bx = coord_t'((int'($urandom % 2001) - 1000) * 256);
        by = coord_t'((int'($urandom % 2001) - 1000) * 256);
        valid_in    = v;
        block_pos_x = EYE_X + bx;
        block_pos_y = EYE_Y + by;
        block_pos_z = coord_t'(int'($urandom % 200001) - 100000);
        ray_x       = bx + coord_t'(dx * 256);
        ray_y       = by + coord_t'(dy * 256);
        ray_z       = block_pos_z + TOP_FACE_HEIGHT + coord_t'(dz);
        t_in        = coord_t'(256);
        block_dir   = arrow_dir_t'(dir);
        block_color = block_color_t'(col);
        if (v) begin
            e = shade_model(block_pos_x, block_pos_y, block_pos_z, ray_x, ray_y, ray_z,
                            t_in, dir, col);
            e.due = cyc + PIPE_STAGES;
            exp_q.push_back(e);
        end
    endtask

    // rgb_valid is expected exactly when the oldest pixel is due
    always @(negedge clk_in) begin : monitor
        expect_t e;
        logic    due_now;
        due_now = (exp_q.size() > 0) && (exp_q[0].due == cyc);
        check_value("rgb_valid", longint'(rgb_valid), longint'(due_now));
        if (due_now) begin
            e = exp_q.pop_front();
            if (rgb_valid) begin
                check_value("r_out", longint'(r_out), longint'(e.r));
                check_value("g_out", longint'(g_out), longint'(e.g));
                check_value("b_out", longint'(b_out), longint'(e.b));
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: results still pending after %0d clock cycles", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        void'($urandom(17619));
        rst_in      = 1'b1;
        valid_in    = 1'b0;
        block_pos_x = '0;
        block_pos_y = '0;
        block_pos_z = '0;
        ray_x       = '0;
        ray_y       = '0;
        ray_z       = '0;
        t_in        = '0;
        block_dir   = UP;
        block_color = BLUE;
        repeat (RESET_CYCLES) @(negedge clk_in);
        rst_in = 1'b0;

        // every direction code against every quadrant, back to back
        for (int q = 0; q < 4; q++) begin
            for (int d = 0; d < 8; d++) begin
                send_pixel(1'b1, quad_dx[q], quad_dy[q], 0, 3'(d), 3'((q + d) % 3));
            end
        end
        // top-face tolerance around the slack
        for (int dz = -2; dz <= 6; dz++) begin
            send_pixel(1'b1, 0, -40, dz, 3'd0, 3'd1);
        end
        // edges of the arrow square
        send_pixel(1'b1, 80, 0, 0, 3'd1, 3'd1);
        send_pixel(1'b1, 79, 0, 0, 3'd1, 3'd1);
        send_pixel(1'b1, 0, -80, 0, 3'd0, 3'd0);
        send_pixel(1'b1, 0, 79, 0, 3'd2, 3'd0);

        for (int i = 0; i < NUM_RANDOM; i++) begin
            send_pixel(($urandom % 4) != 0, int'($urandom % 241) - 120,
                       int'($urandom % 241) - 120,
                       (($urandom % 4) == 0) ? int'($urandom % 4001) - 2000
                                             : int'($urandom % 11) - 4,
                       3'($urandom), 3'($urandom));
        end

        @(negedge clk_in);
        valid_in = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk_in);
        end
        repeat (2) @(negedge clk_in);

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- pixel_pipe_ctrl.sv
`timescale 1ns/10ps

module pixel_pipe_ctrl (
    input  logic                    clk_in,
    input  logic                    rst_in,
    input  logic                    valid_in,
    input  geom_pkg::arrow_dir_t    block_dir,
    input  shade_pkg::block_color_t block_color,
    output geom_pkg::arrow_dir_t    s2_dir,
    output shade_pkg::block_color_t s2_color,
    output logic                    out_strobe
);

    import geom_pkg::*;
    import shade_pkg::*;

    // the last valid stage is rgb_valid in the shader output register
    localparam int CTRL_STAGES = PIPE_STAGES - 1;

    ////////////////////////////////////////
    // valid pipeline

    // bit 0 is stage 1, the top bit is stage 2
    logic [CTRL_STAGES-1:0] valid_sr;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            valid_sr <= '0;
        end else begin
            valid_sr <= {valid_sr[CTRL_STAGES-2:0], valid_in};
        end
    end

    // stage 2 valid, registered into rgb_valid by the shader
    assign out_strobe = valid_sr[CTRL_STAGES-1];

    ////////////////////////////////////////
    // block attributes

    // stage 1 copies, in step with the scaled ray
    arrow_dir_t   s1_dir;
    block_color_t s1_color;

    // two register delay so direction and colour meet the
    // geometry flags at the shader input
    always_ff @(posedge clk_in) begin
        s1_dir   <= block_dir;
        s1_color <= block_color;
        s2_dir   <= s1_dir;
        s2_color <= s1_color;
    end

endmodule

//--- pixel_shader.sv
`timescale 1ns/10ps

module pixel_shader (
    input  logic                    clk_in,
    input  logic                    rst_in,
    input  logic                    in_region_a,
    input  logic                    in_region_c,
    input  logic                    in_bounds,
    input  logic                    ray_left,
    input  logic                    ray_below,
    input  logic                    on_top_face,
    input  geom_pkg::arrow_dir_t    s2_dir,
    input  shade_pkg::block_color_t s2_color,
    input  logic                    out_strobe,
    output shade_pkg::chan_t        r_out,
    output shade_pkg::chan_t        g_out,
    output shade_pkg::chan_t        b_out,
    output logic                    rgb_valid
);

    import geom_pkg::*;
    import shade_pkg::*;

    logic  dir_hit;
    logic  draw_arrow;
    chan_t mat_r;
    chan_t mat_b;
    chan_t mat_max;

    ////////////////////////////////////////
    // arrow decision

    always_comb begin
        case (s2_dir)
            UP:      dir_hit = ray_below && in_region_a && in_region_c;
            RIGHT:   dir_hit = !ray_left && !in_region_a && in_region_c;
            DOWN:    dir_hit = !ray_below && !in_region_a && !in_region_c;
            // LEFT, ANY and the unused codes
            default: dir_hit = ray_left && in_region_a && !in_region_c;
        endcase
        draw_arrow = on_top_face && in_bounds && dir_hit;
    end

    ////////////////////////////////////////
    // material colour

    // without lighting the material is the base colour
    // no material has a green component
    always_comb begin
        mat_r = (s2_color == RED) ? CHAN_ONE : '0;
        mat_b = (s2_color == BLUE) ? CHAN_ONE : '0;

        // brightest channel is painted grey on the arrow
        mat_max = mat_r;
        if (mat_b > mat_max) begin
            mat_max = mat_b;
        end
    end

    ////////////////////////////////////////
    // output register

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            rgb_valid <= 1'b0;
        end else begin
            rgb_valid <= out_strobe;
        end
    end

    // channels hold between pixels
    always_ff @(posedge clk_in) begin
        if (out_strobe) begin
            if (draw_arrow) begin
                r_out <= mat_max;
                g_out <= mat_max;
                b_out <= mat_max;
            end else begin
                r_out <= mat_r;
                g_out <= '0;
                b_out <= mat_b;
            end
        end
    end

endmodule

//--- project.f
geom_pkg.sv
shade_pkg.sv
pixel_pipe_ctrl.sv
ray_scaler.sv
arrow_geometry.sv
pixel_shader.sv
pixel_color.sv
pixel_color_properties.sv
pixel_color_tb.sv

//--- ray_scaler.sv
`timescale 1ns/10ps

module ray_scaler (
    input  logic             clk_in,
    input  geom_pkg::coord_t ray_x,
    input  geom_pkg::coord_t ray_y,
    input  geom_pkg::coord_t ray_z,
    input  geom_pkg::coord_t t_in,
    input  geom_pkg::coord_t block_pos_x,
    input  geom_pkg::coord_t block_pos_y,
    input  geom_pkg::coord_t block_pos_z,
    output geom_pkg::coord_t rel_x,
    output geom_pkg::coord_t rel_y,
    output geom_pkg::coord_t rel_z,
    output geom_pkg::coord_t blk_x,
    output geom_pkg::coord_t blk_y,
    output geom_pkg::coord_t blk_z
);

    import geom_pkg::*;

    // full-width product, then drop FRAC_BITS
    // the slice of a signed product rounds toward minus infinity
    function automatic coord_t scale_by_t(coord_t comp, coord_t t);
        logic signed [2*$bits(coord_t)-1:0] prod;
        prod = comp * t;
        return prod[FRAC_BITS +: $bits(coord_t)];
    endfunction

    always_ff @(posedge clk_in) begin
        // hit point relative to the eye
        rel_x <= scale_by_t(ray_x, t_in);
        rel_y <= scale_by_t(ray_y, t_in);
        rel_z <= scale_by_t(ray_z, t_in);

        // block in the eye frame, z is not shifted
        blk_x <= block_pos_x - EYE_X;
        blk_y <= block_pos_y - EYE_Y;
        blk_z <= block_pos_z;
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build the pixel_color testbench with Verilator and run it
# the run passes only when the log holds the pass line

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module pixel_color_tb \
    -f project.f \
    -o pixel_color_sim \
    && ./obj_dir/pixel_color_sim | tee sim.log \
    || echo "build or simulation did not complete"

grep -qsx "TEST OK" sim.log && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }

//--- shade_pkg.sv
package shade_pkg;

    ////////////////////////////////////////
    // block material

    // other codes are legal, they shade black
    typedef enum logic [2:0] {
        BLUE = 3'd0,
        RED  = 3'd1
    } block_color_t;

    // colour channel, 8 fraction bits
    typedef logic [15:0] chan_t;

    // full intensity, 1.0
    localparam chan_t CHAN_ONE = 16'd256;

    ////////////////////////////////////////
    // pipeline

    // valid_in to rgb_valid, in clock cycles
    localparam int PIPE_STAGES = 3;

endpackage
